// ==== source/stepper_pkg.sv ====
package stepper_pkg;

	// number of steps in one move on one axis, unsigned
	typedef logic [15:0] step_count_t;

	// ticks the step line stays high, and then the same number of ticks low
	typedef logic [11:0] half_period_t;

	// signed axis position in steps, counted at the output register
	typedef logic signed [23:0] position_t;

	// one axis worth of a move command, 29 bits
	typedef struct packed {
		step_count_t steps; // pulses to emit, zero gives an empty move
		logic dir; // 1 moves in the positive direction
		half_period_t half_period; // high and low time of each pulse in ticks
	} axis_cmd_t;

	// full two-axis move as the host hands it over
	typedef struct packed {
		axis_cmd_t x; // command for the x axis
		axis_cmd_t y; // command for the y axis
	} move_cmd_t;

	// raw drive lines of one axis before they reach the output register
	typedef struct packed {
		logic step; // high during the high phase of a pulse
		logic dir; // held for the whole move
	} axis_drive_t;

	// states of the trigger FSM that hands a move to both axes
	typedef enum logic [2:0] {
		standby, // waiting for a trigger, ready for the host
		trigger_hold_both, // neither axis has acknowledged yet
		trigger_hold_x, // y acknowledged, x still held
		trigger_hold_y, // x acknowledged, y still held
		working // both acknowledged, waiting for both to finish
	} xy_fsm_state_t;

	// states of a single axis pulse generator
	typedef enum logic [1:0] {
		idle, // no move in progress
		ack, // zero-step move, working for one tick only
		pulse_high, // step line high
		pulse_low // step line low, then next pulse or done
	} axis_state_t;

endpackage

// ==== source/tick_prescaler.sv ====
module tick_prescaler #(
	parameter int TICK_DIV = 4 // clocks per motion tick
) (
	input logic clk,
	input logic reset,
	output logic clk_en
);

	// a divide by one still needs a one-bit counter to compile
	localparam int CNT_W = (TICK_DIV > 1) ? $clog2(TICK_DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(TICK_DIV - 1);

	logic [CNT_W-1:0] cnt; // free-running position inside the tick period

	// wraps at TICK_DIV-1 and raises clk_en for the following clock
	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			clk_en <= 1'b0; // no motion until the first full period has passed
		end
		else if (cnt == CNT_LAST) begin
			cnt <= '0;
			clk_en <= 1'b1; // one clock wide, or constant when TICK_DIV is 1
		end
		else begin
			cnt <= cnt + 1'b1;
			clk_en <= 1'b0;
		end
	end

endmodule

// ==== source/move_cmd_latch.sv ====
module move_cmd_latch import stepper_pkg::*; (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic start,
	input move_cmd_t cmd,
	input logic is_standby,
	output move_cmd_t latched_cmd,
	output logic trigger,
	output logic ready
);

	logic pending; // a command is stored and the FSM has not taken it yet
	logic accept; // start seen while the controller can take a move

	// a start counts only while ready, so a second strobe is dropped
	assign accept = start & ready;

	// the FSM still shows standby until it moves, pending masks that window
	assign ready = is_standby & ~pending;

	// the FSM only samples on clk_en, so the trigger level has to persist
	assign trigger = pending;

	// command payload, held for the axes until the next accepted start
	always_ff @(posedge clk) begin
		if (accept) begin
			latched_cmd <= cmd; // start may land on any clock, not just a tick
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			pending <= 1'b0;
		end
		else if (accept) begin
			pending <= 1'b1; // is_standby is high here, so no clash with the clear
		end
		else if (clk_en && !is_standby) begin
			pending <= 1'b0; // FSM has left standby and holds the axis triggers now
		end
	end

endmodule

// ==== source/xy_trigger_fsm.sv ====
module xy_trigger_fsm import stepper_pkg::*; (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic trigger,
	input logic working_x,
	input logic working_y,
	output logic trigger_x,
	output logic trigger_y,
	output logic is_standby
);

	xy_fsm_state_t cur_state; // registered state, advances on ticks only
	xy_fsm_state_t nxt_state; // next state from the current inputs

	// outputs depend on the state alone, inputs only steer the transitions
	always_comb begin
		trigger_x = 1'b0;
		trigger_y = 1'b0;
		is_standby = 1'b0;
		nxt_state = cur_state; // stay put unless a branch below says otherwise
		unique case (cur_state)
			standby: begin
				is_standby = 1'b1; // the only state where a new move is taken
				if (trigger) begin
					nxt_state = trigger_hold_both;
				end
			end
			trigger_hold_both: begin
				trigger_x = 1'b1;
				trigger_y = 1'b1;
				if (working_x) begin
					nxt_state = trigger_hold_y; // x took it, keep holding y
				end
				if (working_y) begin
					nxt_state = trigger_hold_x; // y took it, keep holding x
				end
				if (working_x & working_y) begin
					nxt_state = working; // both in the same tick wins over either one
				end
			end
			trigger_hold_x: begin
				trigger_x = 1'b1;
				if (working_x) begin
					nxt_state = working;
				end
			end
			trigger_hold_y: begin
				trigger_y = 1'b1;
				if (working_y) begin
					nxt_state = working;
				end
			end
			working: begin
				// one axis may already be idle again, wait for the slower one
				if (!working_x && !working_y) begin
					nxt_state = standby;
				end
			end
			default: begin
				nxt_state = standby; // unused encodings fall back to a safe state
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cur_state <= standby;
		end
		else if (clk_en) begin
			cur_state <= nxt_state; // the axes sample working on the same tick grid
		end
	end

endmodule

// ==== source/axis_stepper.sv ====
module axis_stepper import stepper_pkg::*; (
	input logic clk,
	input logic reset,
	input logic clk_en,
	input logic trigger,
	input axis_cmd_t axis_cmd,
	output logic working,
	output axis_drive_t drive
);

	axis_state_t state; // pulse generator state
	step_count_t steps_left; // pulses still to finish, including the current one
	half_period_t half_q; // half-period of the running move
	half_period_t tick_cnt; // ticks left in the current phase, minus one
	logic dir_q; // direction of the running move
	logic phase_done; // last tick of the current high or low phase
	logic last_pulse; // the pulse now in its low phase ends the move

	assign phase_done = (tick_cnt == '0);
	assign last_pulse = (steps_left == step_count_t'(1));

	// state and direction carry reset so the outputs start quiet and low
	always_ff @(posedge clk) begin
		if (reset) begin
			state <= idle;
			dir_q <= 1'b0;
		end
		else if (clk_en) begin
			unique case (state)
				idle: begin
					if (trigger) begin
						dir_q <= axis_cmd.dir; // fixed from here to the end of the move
						if (axis_cmd.steps == '0) begin
							state <= ack; // still show working so the FSM sees it
						end
						else begin
							state <= pulse_high;
						end
					end
				end
				ack: begin
					state <= idle; // one tick of working, no pulse
				end
				pulse_high: begin
					if (phase_done) begin
						state <= pulse_low;
					end
				end
				pulse_low: begin
					if (phase_done) begin
						state <= last_pulse ? idle : pulse_high;
					end
				end
				default: begin
					state <= idle;
				end
			endcase
		end
	end

	// counters only matter while a pulse is running, they are loaded on entry
	always_ff @(posedge clk) begin
		if (clk_en) begin
			unique case (state)
				idle: begin
					if (trigger) begin
						steps_left <= axis_cmd.steps;
						half_q <= axis_cmd.half_period;
						tick_cnt <= axis_cmd.half_period - 1'b1; // a zero half-period wraps to the longest phase
					end
				end
				pulse_high: begin
					// reload for the low phase, which lasts as long as the high one
					tick_cnt <= phase_done ? half_q - 1'b1 : tick_cnt - 1'b1;
				end
				pulse_low: begin
					if (phase_done) begin
						steps_left <= steps_left - 1'b1; // one whole pulse is done
						tick_cnt <= half_q - 1'b1;
					end
					else begin
						tick_cnt <= tick_cnt - 1'b1;
					end
				end
				default: begin
					tick_cnt <= tick_cnt; // ack keeps nothing running
				end
			endcase
		end
	end

	assign working = (state != idle); // ack counts as working too
	assign drive.step = (state == pulse_high);
	assign drive.dir = dir_q;

endmodule

// ==== source/axis_position_out.sv ====
module axis_position_out import stepper_pkg::*; #(
	parameter int POS_W = 24 // width of the position counters
) (
	input logic clk,
	input logic reset,
	input axis_drive_t drive_x,
	input axis_drive_t drive_y,
	output logic step_x,
	output logic dir_x,
	output logic step_y,
	output logic dir_y,
	output position_t pos_x,
	output position_t pos_y
);

	// the counters below are position_t wide, a mismatch is a setup error
	if (POS_W != $bits(position_t)) begin : g_pos_w_check
		$error("POS_W does not match the width of position_t");
	end

	axis_drive_t [1:0] drive_in; // index 0 is x, index 1 is y
	axis_drive_t [1:0] drive_q; // registered drive lines seen by the motor driver
	logic [1:0] step_prev; // registered step one clock later, for edge detect
	position_t [1:0] pos; // signed step count per axis

	assign drive_in[0] = drive_x;
	assign drive_in[1] = drive_y;

	// counting from the registered lines keeps pos in step with what leaves the chip
	always_ff @(posedge clk) begin
		if (reset) begin
			drive_q <= '0;
			step_prev <= '0;
			pos <= '0;
		end
		else begin
			for (int i = 0; i < 2; i++) begin
				drive_q[i] <= drive_in[i];
				step_prev[i] <= drive_q[i].step;
				if (drive_q[i].step && !step_prev[i]) begin
					// dir is settled before the first rising step of a move
					pos[i] <= drive_q[i].dir ? pos[i] + 1'b1 : pos[i] - 1'b1;
				end
			end
		end
	end

	assign step_x = drive_q[0].step;
	assign dir_x = drive_q[0].dir;
	assign step_y = drive_q[1].step;
	assign dir_y = drive_q[1].dir;
	assign pos_x = pos[0];
	assign pos_y = pos[1];

endmodule

// ==== source/stepper_xy_top.sv ====
module stepper_xy_top import stepper_pkg::*; #(
	parameter int TICK_DIV = 4, // clocks per motion tick
	parameter int POS_W = 24 // position width, must match position_t
) (
	input logic clk,
	input logic reset,
	input logic start,
	input move_cmd_t cmd,
	output logic ready,
	output logic step_x,
	output logic dir_x,
	output logic step_y,
	output logic dir_y,
	output position_t pos_x,
	output position_t pos_y
);

	logic clk_en; // one clock in TICK_DIV, paces the FSM and the axes
	logic is_standby; // FSM can take a new move
	logic trigger; // latched move waiting for the FSM
	move_cmd_t latched_cmd; // move held for both axes
	logic trigger_x; // held until the x axis reports working
	logic trigger_y; // held until the y axis reports working
	logic working_x;
	logic working_y;
	axis_drive_t drive_x; // unregistered x step and dir
	axis_drive_t drive_y; // unregistered y step and dir

	tick_prescaler #(.TICK_DIV(TICK_DIV)) u_tick (
		.clk, .reset, .clk_en
	);

	move_cmd_latch u_latch (
		.clk, .reset, .clk_en, .start, .cmd, .is_standby,
		.latched_cmd, .trigger, .ready
	);

	xy_trigger_fsm u_fsm (
		.clk, .reset, .clk_en, .trigger, .working_x, .working_y,
		.trigger_x, .trigger_y, .is_standby
	);

	axis_stepper axis_x (
		.clk, .reset, .clk_en, .trigger(trigger_x), .axis_cmd(latched_cmd.x),
		.working(working_x), .drive(drive_x)
	);

	axis_stepper axis_y (
		.clk, .reset, .clk_en, .trigger(trigger_y), .axis_cmd(latched_cmd.y),
		.working(working_y), .drive(drive_y)
	);

	axis_position_out #(.POS_W(POS_W)) u_out (
		.clk, .reset, .drive_x, .drive_y,
		.step_x, .dir_x, .step_y, .dir_y, .pos_x, .pos_y
	);

endmodule

// ==== tb/stepper_xy_asserts.sv ====
module xy_fsm_asserts (
	input logic clk,
	input logic reset,
	input logic idle_flag, // standby as the host sees it, tied low on an axis
	input logic hold_a, // trigger that has to stay up until ack_a answers
	input logic hold_b, // second trigger, tied low on an axis
	input logic ack_a, // working that answers hold_a
	input logic ack_b, // working that answers hold_b
	input logic busy, // axis is running a move, tied low in the FSM
	input logic dir_line // direction the axis drives for the running move
);

	// a held trigger means the FSM already left standby
	standby_no_trigger: assert property (@(posedge clk) disable iff (reset)
		!(idle_flag && (hold_a || hold_b)))
		else $error("a trigger is high while the FSM is in standby");

	// the trigger may only drop on a tick where its axis already answered
	trigger_a_held: assert property (@(posedge clk) disable iff (reset)
		$fell(hold_a) |-> $past(ack_a))
		else $error("first trigger dropped before its axis reported working");

	trigger_b_held: assert property (@(posedge clk) disable iff (reset)
		$fell(hold_b) |-> $past(ack_b))
		else $error("second trigger dropped before its axis reported working");

	// dir is loaded on the idle exit and then frozen until the move ends
	dir_stable: assert property (@(posedge clk) disable iff (reset)
		(busy && $past(busy)) |-> $stable(dir_line))
		else $error("axis direction changed in the middle of a move");

endmodule

// the FSM holds both triggers, it has no direction of its own
bind xy_trigger_fsm xy_fsm_asserts u_fsm_asserts (
	.clk, .reset, .idle_flag(is_standby), .hold_a(trigger_x), .hold_b(trigger_y),
	.ack_a(working_x), .ack_b(working_y), .busy(1'b0), .dir_line(1'b0)
);

// each axis sees one trigger and owns one direction line
bind axis_stepper xy_fsm_asserts u_axis_asserts (
	.clk, .reset, .idle_flag(1'b0), .hold_a(trigger), .hold_b(1'b0),
	.ack_a(working), .ack_b(1'b0), .busy(working), .dir_line(drive.dir)
);

// ==== tb/stepper_xy_tb.sv ====
module stepper_xy_tb import stepper_pkg::*; ();

	localparam int TICK_DIV = 4; // clocks per motion tick in the DUT

	// a move needs at most (2*H*N + 8) ticks, summed over every move issued below
	localparam int TIMEOUT_CYCLES = (2 * 2 * 5 + 8) * TICK_DIV // basic move
		+ (2 * 3 * 4 + 8) * TICK_DIV // pulse widths, slower axis
		+ (2 * 2 * 4 + 8) * TICK_DIV // zero-step axis
		+ (2 * 2 * 6 + 8) * TICK_DIV // ignored second start
		+ 10 * (2 * 7 * 15 + 8) * TICK_DIV // ten random moves at their largest
		+ 1000; // reset, gaps between tests and start latency

	logic clk;
	logic reset;
	logic start;
	move_cmd_t cmd;
	logic ready;
	logic step_x;
	logic dir_x;
	logic step_y;
	logic dir_y;
	position_t pos_x;
	position_t pos_y;

	int cycle_cnt = 0; // clocks since time zero, compared with the limit
	int seed; // $random state for the random moves
	int exp_x; // running signed sum of commanded x steps
	int exp_y; // running signed sum of commanded y steps
	int n_pulses [2]; // rising step edges in the current move, index 0 is x
	int level_len [2]; // samples since the last edge on each step line
	logic prev_step [2]; // step level at the previous sample
	string axis_name [2]; // suffix used in the error lines

	stepper_xy_top #(.TICK_DIV(TICK_DIV), .POS_W(24)) DUT (
		.clk, .reset, .start, .cmd, .ready,
		.step_x, .dir_x, .step_y, .dir_y, .pos_x, .pos_y
	);

	initial clk = 1'b0;
	always #20 clk = ~clk; // 40 time units per cycle

	always @(posedge clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if (cycle_cnt >= TIMEOUT_CYCLES) begin
			stop_with_failure($sformatf("timeout, the tests did not finish in %0d cycles",
				TIMEOUT_CYCLES));
		end
	end

	task automatic stop_with_failure(input string why);
		$display("%s", why);
		$display("TB FAILED");
		$fatal(1, "run stopped at the first failure");
	endtask

	task automatic check_position(input string name, input position_t exp, input position_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_count(input string name, input step_count_t exp, input step_count_t act);
		if (act !== exp) begin
			stop_with_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
		end
	endtask

	task automatic check_bit(input string name, input logic exp, input logic act);
		if (act !== exp) begin
			stop_with_failure($sformatf("ERR %s expected %h actual %h", name, exp, act));
		end
	endtask

	function automatic axis_cmd_t make_axis(input int steps, input int dir, input int half);
		axis_cmd_t ac;
		ac.steps = step_count_t'(steps);
		ac.dir = (dir != 0); // any nonzero value means the positive direction
		ac.half_period = half_period_t'(half);
		return ac;
	endfunction

	// one sample of one step line, widths are measured edge to edge in clocks
	task automatic track_axis(input int a, input logic step, input logic dir, input axis_cmd_t ac);
		step_count_t want_len; // high and low phase length in clocks
		want_len = step_count_t'(ac.half_period * TICK_DIV);
		if (step) begin
			check_bit({"dir_", axis_name[a]}, ac.dir, dir); // dir must match during every pulse
		end
		if (step !== prev_step[a]) begin
			if (prev_step[a]) begin
				check_count({"step_", axis_name[a], " high width"}, want_len,
					step_count_t'(level_len[a]));
			end
			else if (n_pulses[a] > 0) begin
				// low time before the first pulse is start latency, not a phase
				check_count({"step_", axis_name[a], " low width"}, want_len,
					step_count_t'(level_len[a]));
			end
			if (step) begin
				n_pulses[a]++;
			end
			level_len[a] = 1; // this sample is the first of the new level
		end
		else begin
			level_len[a]++;
		end
		prev_step[a] = step;
	endtask

	// issues one move, optionally with a second start while busy, and checks the result
	task automatic run_move(input move_cmd_t c, input bit inject);
		move_cmd_t bogus; // a different move that must never reach the axes
		int clk_n; // samples since start was released
		bogus = c;
		bogus.x.steps = c.x.steps + 16'd7;
		bogus.y.steps = c.y.steps + 16'd9;
		@(negedge clk);
		check_bit("ready", 1'b1, ready);
		cmd = c;
		start = 1'b1;
		@(negedge clk);
		start = 1'b0;
		for (int a = 0; a < 2; a++) begin
			n_pulses[a] = 0;
			level_len[a] = 0;
			prev_step[a] = 1'b0;
		end
		clk_n = 0;
		while (ready !== 1'b1) begin
			track_axis(0, step_x, dir_x, c.x);
			track_axis(1, step_y, dir_y, c.y);
			if (inject && clk_n == 0) begin
				check_bit("ready", 1'b0, ready); // the FSM may still be in standby here
				cmd = bogus;
				start = 1'b1;
			end
			else begin
				start = 1'b0;
			end
			clk_n++;
			@(negedge clk);
		end
		start = 1'b0;
		check_count("step_x pulses", c.x.steps, step_count_t'(n_pulses[0]));
		check_count("step_y pulses", c.y.steps, step_count_t'(n_pulses[1]));
		exp_x += c.x.dir ? int'(c.x.steps) : -int'(c.x.steps);
		exp_y += c.y.dir ? int'(c.y.steps) : -int'(c.y.steps);
		check_position("pos_x", position_t'(exp_x), pos_x);
		check_position("pos_y", position_t'(exp_y), pos_y);
	endtask

	task automatic test_reset_and_basic();
		move_cmd_t m;
		check_bit("ready", 1'b1, ready);
		check_position("pos_x", position_t'(0), pos_x);
		check_position("pos_y", position_t'(0), pos_y);
		m.x = make_axis(5, 1, 2);
		m.y = make_axis(3, 0, 2);
		run_move(m, 1'b0);
		check_position("pos_x", position_t'(5), pos_x);
		check_position("pos_y", position_t'(-3), pos_y);
	endtask

	task automatic test_pulse_widths();
		move_cmd_t m;
		m.x = make_axis(4, 1, 1); // shortest phase, one tick each
		m.y = make_axis(4, 1, 3);
		run_move(m, 1'b0);
	endtask

	task automatic test_zero_axis();
		move_cmd_t m;
		m.x = make_axis(0, 1, 2); // x only flashes working for one tick
		m.y = make_axis(4, 0, 2);
		run_move(m, 1'b0);
	endtask

	task automatic test_ignored_start();
		move_cmd_t m;
		m.x = make_axis(6, 0, 2);
		m.y = make_axis(2, 1, 2);
		run_move(m, 1'b1);
	endtask

	task automatic test_random_moves();
		move_cmd_t m;
		for (int i = 0; i < 10; i++) begin
			m.x = make_axis($unsigned($random(seed)) % 16, $random(seed) & 1,
				1 + int'($unsigned($random(seed)) % 7));
			m.y = make_axis($unsigned($random(seed)) % 16, $random(seed) & 1,
				1 + int'($unsigned($random(seed)) % 7));
			run_move(m, 1'b0);
		end
	endtask

	initial begin
		seed = 32'ha836_1ff5;
		exp_x = 0;
		exp_y = 0;
		axis_name[0] = "x";
		axis_name[1] = "y";
		reset = 1'b1;
		start = 1'b0;
		cmd = '0;
		repeat (5) @(posedge clk);
		@(negedge clk);
		reset = 1'b0;
		test_reset_and_basic();
		test_pulse_widths();
		test_zero_axis();
		test_ignored_start();
		test_random_moves();
		$display("TB PASSED");
		$finish;
	end

endmodule

// ==== stepper_xy.f ====
source/stepper_pkg.sv
source/tick_prescaler.sv
source/move_cmd_latch.sv
source/xy_trigger_fsm.sv
source/axis_stepper.sv
source/axis_position_out.sv
source/stepper_xy_top.sv
tb/stepper_xy_asserts.sv
tb/stepper_xy_tb.sv

// ==== Makefile ====
# Verilator build and run for the stepper_xy testbench

SRCS := $(wildcard source/*.sv) $(wildcard tb/*.sv)

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
obj_dir/Vstepper_xy_tb: stepper_xy.f $(SRCS)
	verilator --binary --timing --assert -sv --top-module stepper_xy_tb -f stepper_xy.f

# the log decides the result, a missing pass line also fails
run: obj_dir/Vstepper_xy_tb
	./obj_dir/Vstepper_xy_tb > sim.log 2>&1 || true
	cat sim.log
	! grep -q "TB FAILED" sim.log
	grep -q "TB PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
